//--- Makefile
TOP = alu_block_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f flist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- alu_block.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu_block (
    input  logic            clk,
    input  logic            reset,
    input  alu_pkg::sel_t   outctl,
    input  alu_pkg::sel_t   loadctl,
    input  alu_pkg::argl_t  arg_l,
    input  alu_pkg::argr_t  arg_r,
    input  logic            alt,
    input  logic            calc,
    input  logic            cin,
    input  alu_pkg::data_t  ext_data,
    output alu_pkg::data_t  bus_out,
    output alu_pkg::flags_t fout
);
    import alu_pkg::*;

    data_t  main_bus;
    data_t  left;
    data_t  right;
    data_t  reg_a;
    data_t  reg_b;
    data_t  reg_c;
    data_t  reg_d;
    data_t  alu_bus;
    flags_t flags;
    logic   cout;
    logic   vout;
    logic   carry_in;

    // ----------------------------------------------
    // microcode fields onto the control interface
    // ----------------------------------------------
    alu_ctl_if ctl ();

    assign ctl.outctl  = outctl;
    assign ctl.loadctl = loadctl;
    assign ctl.arg_l   = arg_l;
    assign ctl.arg_r   = arg_r;
    assign ctl.alt     = alt;
    assign ctl.calc    = calc;
    assign ctl.cin     = cin;

    reg_file i_regs (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl.regs),
        .bus   (main_bus),
        .left  (left),
        .right (right),
        .reg_a (reg_a),
        .reg_b (reg_b),
        .reg_c (reg_c),
        .reg_d (reg_d)
    );

    alu_core i_alu (
        .ctl      (ctl.alu),
        .left     (left),
        .right    (right),
        .carry_in (carry_in),
        .result   (alu_bus),
        .cout     (cout),
        .vout     (vout)
    );

    flags_reg i_flags (
        .clk      (clk),
        .reset    (reset),
        .ctl      (ctl.flags),
        .bus      (main_bus),
        .cout     (cout),
        .vout     (vout),
        .cin_ext  (ctl.cin),
        .flags    (flags),
        .carry_in (carry_in)
    );

    // ----------------------------------------------
    // main bus source mux
    // ----------------------------------------------
    always_comb begin
        case (ctl.outctl)
            `OUT_A:         main_bus = reg_a;
            `OUT_B:         main_bus = reg_b;
            `OUT_C:         main_bus = reg_c;
            `OUT_D:         main_bus = reg_d;
            `OUT_F:         main_bus = data_t'(flags);
            `OUT_ADDSUB,
            `OUT_ANDOR,
            `OUT_SHIFTSWAP,
            `OUT_XORNOT:    main_bus = alu_bus;
            `OUT_EXT:       main_bus = ext_data;
            default:        main_bus = '0;
        endcase
    end

    assign bus_out = main_bus;
    assign fout    = flags;

endmodule

`default_nettype wire

//--- alu_block_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu_block_tb;
    import alu_pkg::*;

    // the tests take about 500 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 2000;
    localparam logic [3:0] LOAD_NONE = 4'd8;

    logic   clk;
    logic   reset;
    sel_t   outctl;
    sel_t   loadctl;
    argl_t  arg_l;
    argr_t  arg_r;
    logic   alt;
    logic   calc;
    logic   cin;
    data_t  ext_data;
    data_t  bus_out;
    flags_t fout;

    integer seed;
    int     cycles;
    data_t  regs_m [4];
    flags_t flags_m;

    tb_clock i_clock (.clk(clk));

    alu_block i_dut (
        .clk      (clk),
        .reset    (reset),
        .outctl   (outctl),
        .loadctl  (loadctl),
        .arg_l    (arg_l),
        .arg_r    (arg_r),
        .alt      (alt),
        .calc     (calc),
        .cin      (cin),
        .ext_data (ext_data),
        .bus_out  (bus_out),
        .fout     (fout)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Errors found");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // drives one microcode word on the falling edge and lets the bus settle
    task automatic set_inputs(input logic [3:0] out_c, input logic [3:0] load_c,
                              input logic [1:0] al, input logic [2:0] ar,
                              input logic alt_c, input logic calc_c, input logic cin_c,
                              input logic [7:0] ext);
        @(negedge clk);
        outctl   = out_c;
        loadctl  = load_c;
        arg_l    = al;
        arg_r    = ar;
        alt      = alt_c;
        calc     = calc_c;
        cin      = cin_c;
        ext_data = ext;
        #2;
    endtask

    task automatic write_reg(input int idx, input logic [7:0] value);
        set_inputs(`OUT_EXT, 4'(idx), 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, value);
        regs_m[idx] = value;
    endtask

    task automatic write_flags(input logic [7:0] value);
        set_inputs(`OUT_EXT, `LOAD_F, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, value);
        flags_m = value[3:0];
    endtask

    // returns {carry, overflow, sum}, subtract adds the inverted right operand
    function automatic logic [9:0] addsub_model(input logic [7:0] l, input logic [7:0] r,
                                                input logic c, input logic sub);
        logic [7:0] rr;
        logic [8:0] u;
        integer     sl;
        integer     sr;
        integer     s_sum;
        rr    = sub ? ~r : r;
        u     = {1'b0, l} + {1'b0, rr} + {8'd0, c};
        sl    = $signed(l);
        sr    = $signed(rr);
        s_sum = sl + sr + (c ? 1 : 0);
        return {u[8], (s_sum > 127) || (s_sum < -128), u[7:0]};
    endfunction

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_reset();
        for (int code = 0; code <= 4; code++) begin
            set_inputs(4'(code), LOAD_NONE, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'hff);
            check(bus_out, 8'h00, "bus after reset");
            check({4'b0, fout}, 8'h00, "flags after reset");
        end
    endtask

    task automatic test_reg_load();
        logic [7:0] v;
        for (int i = 0; i < 4; i++) begin
            v = 8'($random(seed));
            write_reg(i, v);
            set_inputs(4'(i), LOAD_NONE, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00);
            check(bus_out, v, "register read back");
        end
    endtask

    task automatic test_addsub();
        logic [7:0] a;
        logic [7:0] b;
        logic [9:0] res;
        for (int n = 0; n < 20; n++) begin
            for (int c = 0; c < 2; c++) begin
                for (int s = 0; s < 2; s++) begin
                    a = 8'($random(seed));
                    b = 8'($random(seed));
                    write_reg(0, a);
                    write_reg(1, b);
                    res = addsub_model(a, b, (c == 1) ? 1'b1 : flags_m[0], s == 1);
                    set_inputs(`OUT_ADDSUB, LOAD_NONE, 2'd0, 3'd1, s == 1, 1'b1, c == 1, 8'h00);
                    check(bus_out, res[7:0], "add/sub result");
                    flags_m = {res[7], res[7:0] == 8'h00, res[8], res[9]};
                    set_inputs(`OUT_F, LOAD_NONE, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00);
                    check({4'b0, fout}, {4'b0, flags_m}, "add/sub flags");
                end
            end
        end
        // zero left operand plus the forced zero right operand
        write_flags(8'h00);
        write_reg(0, 8'h00);
        set_inputs(`OUT_ADDSUB, LOAD_NONE, 2'd0, `ARG_R_ZERO, 1'b0, 1'b1, 1'b0, 8'h00);
        check(bus_out, 8'h00, "zero sum");
        set_inputs(`OUT_F, LOAD_NONE, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00);
        check({4'b0, fout}, 8'h04, "zero flag");
        flags_m = 4'h4;
    endtask

    task automatic test_logic();
        logic [7:0] l;
        logic [7:0] r;
        logic [7:0] y;
        for (int i = 0; i < 4; i++) begin
            write_reg(i, 8'($random(seed)));
        end
        for (int op = 0; op < 4; op++) begin
            for (int al = 0; al < 4; al++) begin
                for (int ar = 0; ar < 8; ar++) begin
                    l = regs_m[al];
                    r = (ar < 4) ? regs_m[ar] : 8'h00;
                    case (op)
                        0:       y = l & r;
                        1:       y = l | r;
                        2:       y = l ^ r;
                        default: y = ~l;
                    endcase
                    set_inputs((op < 2) ? `OUT_ANDOR : `OUT_XORNOT, LOAD_NONE, 2'(al),
                               3'(ar), op[0], 1'b0, 1'b0, 8'h00);
                    check(bus_out, y, "logic unit result");
                end
            end
        end
    endtask

    task automatic test_shift_swap();
        logic [7:0] a;
        logic [7:0] y;
        logic [9:0] res;
        write_flags(8'h00);
        a = 8'($random(seed));
        write_reg(0, a);
        // each shift writes back to A, so the carry rotates through nine bits
        for (int n = 0; n < 10; n++) begin
            y   = {a[6:0], flags_m[0]};
            res = addsub_model(a, 8'h00, flags_m[0], 1'b0);
            set_inputs(`OUT_SHIFTSWAP, `LOAD_A, 2'd0, `ARG_R_ZERO, 1'b0, 1'b1, 1'b0, 8'h00);
            check({4'b0, fout}, {4'b0, flags_m}, "flags before shift");
            check(bus_out, y, "shift result");
            flags_m   = {y[7], y == 8'h00, res[8], a[7]};
            a         = y;
            regs_m[0] = y;
        end
        for (int n = 0; n < 4; n++) begin
            a = 8'($random(seed));
            write_reg(2, a);
            res = addsub_model(a, 8'h00, flags_m[0], 1'b0);
            set_inputs(`OUT_SHIFTSWAP, LOAD_NONE, 2'd2, `ARG_R_ZERO, 1'b1, 1'b1, 1'b0, 8'h00);
            check(bus_out, {a[3:0], a[7:4]}, "nibble swap");
            flags_m = {a[3], a == 8'h00, res[8], 1'b0};
            set_inputs(`OUT_F, LOAD_NONE, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00);
            check({4'b0, fout}, {4'b0, flags_m}, "swap flags");
        end
    endtask

    task automatic test_flag_load();
        logic [7:0] v;
        v = 8'($random(seed));
        // N from a calc strobe would be bit 7, so bit 3 is made to differ from it
        v[3] = ~v[7];
        set_inputs(`OUT_EXT, `LOAD_F, 2'd0, 3'd0, 1'b0, 1'b1, 1'b0, v);
        set_inputs(`OUT_F, LOAD_NONE, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00);
        check({4'b0, fout}, {4'b0, v[3:0]}, "flags loaded from bus");
        check(bus_out, {4'b0, v[3:0]}, "flags on the bus");
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        seed     = 36169;
        cycles   = 0;
        reset    = 1'b1;
        outctl   = `OUT_A;
        loadctl  = LOAD_NONE;
        arg_l    = 2'd0;
        arg_r    = 3'd0;
        alt      = 1'b0;
        calc     = 1'b0;
        cin      = 1'b0;
        ext_data = 8'h00;
        flags_m  = 4'h0;
        for (int i = 0; i < 4; i++) begin
            regs_m[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset();
        test_reg_load();
        test_addsub();
        test_logic();
        test_shift_swap();
        test_flag_load();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// width of the main bus and of every register
`define DATA_W 8

// ----------------------------------------------
// bus source codes for outctl
// ----------------------------------------------
`define OUT_A         4'd0
`define OUT_B         4'd1
`define OUT_C         4'd2
`define OUT_D         4'd3
`define OUT_F         4'd4
`define OUT_ADDSUB    4'd5
`define OUT_ANDOR     4'd6
`define OUT_SHIFTSWAP 4'd7
`define OUT_XORNOT    4'd10
`define OUT_EXT       4'd15

// ----------------------------------------------
// destination codes for loadctl
// ----------------------------------------------
`define LOAD_A 4'd0
`define LOAD_B 4'd1
`define LOAD_C 4'd2
`define LOAD_D 4'd3
`define LOAD_F 4'd7

// right operand forced to zero, codes 4, 5 and 7 do the same
`define ARG_R_ZERO 3'd6

`endif

//--- alu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu_core (
    alu_ctl_if.alu         ctl,
    input  alu_pkg::data_t left,
    input  alu_pkg::data_t right,
    input  logic           carry_in,
    output alu_pkg::data_t result,
    output logic           cout,
    output logic           vout
);
    import alu_pkg::*;

    data_t            addend;
    logic [`DATA_W:0] sum;
    data_t            addsub_y;
    data_t            andor_y;
    data_t            xornot_y;
    data_t            shiftswap_y;
    logic             shift_cout;

    // ----------------------------------------------
    // add/subtract
    // ----------------------------------------------

    // subtract adds the inverted right operand, so the carry is a not-borrow
    assign addend   = ctl.alt ? ~right : right;
    assign sum      = {1'b0, left} + {1'b0, addend} + {{`DATA_W{1'b0}}, carry_in};
    assign addsub_y = sum[`DATA_W-1:0];

    // signed overflow when both inputs agree in sign and the sum does not
    assign vout = (left[`DATA_W-1] == addend[`DATA_W-1]) &&
                  (addsub_y[`DATA_W-1] != left[`DATA_W-1]);

    // ----------------------------------------------
    // logic units
    // ----------------------------------------------
    assign andor_y  = ctl.alt ? (left | right) : (left & right);
    assign xornot_y = ctl.alt ? ~left : (left ^ right);

    // rotate through carry on the left, or swap the two nibbles
    always_comb begin
        if (ctl.alt) begin
            shiftswap_y = {left[`DATA_W/2-1:0], left[`DATA_W-1:`DATA_W/2]};
            shift_cout  = 1'b0;
        end else begin
            shiftswap_y = {left[`DATA_W-2:0], carry_in};
            shift_cout  = left[`DATA_W-1];
        end
    end

    // carry follows whichever unit drives the bus
    assign cout = (ctl.outctl == `OUT_SHIFTSWAP) ? shift_cout : sum[`DATA_W];

    always_comb begin
        case (ctl.outctl)
            `OUT_ADDSUB:    result = addsub_y;
            `OUT_ANDOR:     result = andor_y;
            `OUT_XORNOT:    result = xornot_y;
            `OUT_SHIFTSWAP: result = shiftswap_y;
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_ctl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface alu_ctl_if;
    import alu_pkg::*;

    sel_t  outctl;
    sel_t  loadctl;
    argl_t arg_l;
    argr_t arg_r;
    logic  alt;
    logic  calc;

    // external carry request, handed to the flags block by the top
    logic  cin;

    // register file needs the destination and both operand selects
    modport regs (
        input loadctl,
        input arg_l,
        input arg_r
    );

    // alt picks the second function of each unit
    modport alu (
        input alt,
        input outctl
    );

    modport flags (
        input loadctl,
        input calc
    );

endinterface

`default_nettype wire

//--- alu_pkg.sv
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

    // one word on the main bus
    typedef logic [`DATA_W-1:0] data_t;

    // flags word, bit 0 is C, bit 1 is V, bit 2 is Z and bit 3 is N
    typedef logic [3:0] flags_t;

    // ----------------------------------------------
    // microcode select fields
    // ----------------------------------------------

    // output and load select codes
    typedef logic [3:0] sel_t;

    // left operand picks one of A to D
    typedef logic [1:0] argl_t;

    // right operand picks one of A to D or zero
    typedef logic [2:0] argr_t;

endpackage

`default_nettype wire

//--- flags_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module flags_reg (
    input  logic            clk,
    input  logic            reset,
    alu_ctl_if.flags        ctl,
    input  alu_pkg::data_t  bus,
    input  logic            cout,
    input  logic            vout,
    input  logic            cin_ext,
    output alu_pkg::flags_t flags,
    output logic            carry_in
);
    import alu_pkg::*;

    logic bus_zero;

    assign bus_zero = (bus == '0);

    // a direct load from the bus takes priority over a calc strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (ctl.loadctl == `LOAD_F) begin
            flags <= flags_t'(bus);
        end else if (ctl.calc) begin
            flags <= {bus[`DATA_W-1], bus_zero, vout, cout};
        end
    end

    // external carry forces a one, otherwise the stored C flag chains
    assign carry_in = cin_ext ? 1'b1 : flags[0];

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
alu_pkg.sv
alu_ctl_if.sv
reg_file.sv
alu_core.sv
flags_reg.sv
alu_block.sv
tb_clock.sv
alu_block_tb.sv

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module reg_file (
    input  logic           clk,
    input  logic           reset,
    alu_ctl_if.regs        ctl,
    input  alu_pkg::data_t bus,
    output alu_pkg::data_t left,
    output alu_pkg::data_t right,
    output alu_pkg::data_t reg_a,
    output alu_pkg::data_t reg_b,
    output alu_pkg::data_t reg_c,
    output alu_pkg::data_t reg_d
);
    import alu_pkg::*;

    // ----------------------------------------------
    // general registers, loaded from the main bus
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= '0;
            reg_b <= '0;
            reg_c <= '0;
            reg_d <= '0;
        end else begin
            case (ctl.loadctl)
                `LOAD_A: reg_a <= bus;
                `LOAD_B: reg_b <= bus;
                `LOAD_C: reg_c <= bus;
                `LOAD_D: reg_d <= bus;
                default: ;
            endcase
        end
    end

    // ----------------------------------------------
    // operand selection for the ALU
    // ----------------------------------------------
    always_comb begin
        case (ctl.arg_l)
            2'd0:    left = reg_a;
            2'd1:    left = reg_b;
            2'd2:    left = reg_c;
            default: left = reg_d;
        endcase
    end

    // the upper codes give a zero operand for increments and compares
    always_comb begin
        case (ctl.arg_r)
            3'd0:        right = reg_a;
            3'd1:        right = reg_b;
            3'd2:        right = reg_c;
            3'd3:        right = reg_d;
            `ARG_R_ZERO: right = '0;
            default:     right = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period, starting low
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

`default_nettype wire
